// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // datapath and instruction word
    localparam int dataW    = 16;
    // program rom depth is 2**addrW words
    localparam int addrW    = 10;
    localparam int regCount = 16;
    // opcode, register index and port number fields
    localparam int fieldW   = 4;
    // physical gpio input pins
    localparam int pinW     = 8;

    // opcodes in instr[15:12]
    localparam logic [fieldW-1:0] opNop = 4'h0;
    localparam logic [fieldW-1:0] opLdi = 4'h1;
    localparam logic [fieldW-1:0] opAdd = 4'h2;
    localparam logic [fieldW-1:0] opSub = 4'h3;
    localparam logic [fieldW-1:0] opAnd = 4'h4;
    localparam logic [fieldW-1:0] opBz  = 4'h5;
    localparam logic [fieldW-1:0] opBnz = 4'h6;
    localparam logic [fieldW-1:0] opIn  = 4'h7;
    localparam logic [fieldW-1:0] opOut = 4'h8;

    // output ports
    localparam logic [fieldW-1:0] portData   = 4'h0;
    localparam logic [fieldW-1:0] portStatus = 4'h1;
    // input ports
    localparam logic [fieldW-1:0] portPins   = 4'h0;

    // fetch to decode, 27 bits
    typedef struct packed {
        logic             valid;
        logic [addrW-1:0] pc;
        logic [dataW-1:0] instr;
    } fetchT;

    // decode to execute, 63 bits
    typedef struct packed {
        logic              valid;
        logic [fieldW-1:0] op;
        logic [fieldW-1:0] rd;
        logic [fieldW-1:0] port;
        logic [dataW-1:0]  opA;
        logic [dataW-1:0]  opB;
        logic [7:0]        imm8;
        logic [addrW-1:0]  pc;
    } decodeT;

    // register write, also the bypass source
    typedef struct packed {
        logic              en;
        logic [fieldW-1:0] addr;
        logic [dataW-1:0]  data;
    } wbT;

    typedef struct packed {
        logic             taken;
        logic [addrW-1:0] target;
    } redirectT;

    typedef struct packed {
        logic              we;
        logic [fieldW-1:0] port;
        logic [dataW-1:0]  data;
    } ioWrT;

endpackage

`default_nettype wire

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic             clk,
    input  logic             arstN,
    input  cpuPkg::fetchT    fetchIn,
    input  cpuPkg::wbT       wb,
    input  cpuPkg::redirectT redirect,
    output cpuPkg::decodeT   decodeOut
);
    import cpuPkg::*;

    logic [dataW-1:0]  regFile [regCount];
    logic [fieldW-1:0] op;
    logic [fieldW-1:0] rd;
    logic [fieldW-1:0] ra;
    logic [fieldW-1:0] rb;
    logic [fieldW-1:0] srcA;
    decodeT            decodeNext;
    decodeT            payloadQ;
    logic              validQ;

    // r0 reads zero, then bypass, then array
    function automatic logic [dataW-1:0] readReg(input logic [fieldW-1:0] idx);
        logic [dataW-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.en && wb.addr == idx) begin
            // execute result not yet in the array
            value = wb.data;
        end else begin
            value = regFile[idx];
        end
        return value;
    endfunction

    // instruction fields
    assign op = fetchIn.instr[15:12];
    assign rd = fetchIn.instr[11:8];
    assign ra = fetchIn.instr[7:4];
    assign rb = fetchIn.instr[3:0];

    // branches and OUT name their source in the rd slot
    assign srcA = (op == opBz || op == opBnz || op == opOut) ? rd : ra;

    always_comb begin
        decodeNext.valid = fetchIn.valid && !redirect.taken;
        decodeNext.op    = op;
        decodeNext.rd    = rd;
        decodeNext.port  = rb;
        decodeNext.opA   = readReg(srcA);
        decodeNext.opB   = readReg(rb);
        decodeNext.imm8  = fetchIn.instr[7:0];
        decodeNext.pc    = fetchIn.pc;
    end

    // register file, write lands at the end of execute
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regFile[wb.addr] <= wb.data;
        end
    end

    // pipeline register, valid squashed by a redirect
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= decodeNext.valid;
        end
    end

    always_ff @(posedge clk) begin
        payloadQ <= decodeNext;
    end

    always_comb begin
        decodeOut       = payloadQ;
        decodeOut.valid = validQ;
    end

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  cpuPkg::decodeT           decodeIn,
    input  logic [cpuPkg::dataW-1:0] pinData,
    output cpuPkg::wbT               wb,
    output cpuPkg::redirectT         redirect,
    output cpuPkg::ioWrT             ioWr
);
    import cpuPkg::*;

    logic [addrW-1:0] branchOffset;
    logic [dataW-1:0] result;
    logic             writesReg;

    // signed 8 bit offset, relative to the branch itself
    assign branchOffset = {{(addrW-8){decodeIn.imm8[7]}}, decodeIn.imm8};

    // alu and input mux
    always_comb begin
        result    = '0;
        writesReg = 1'b0;
        case (decodeIn.op)
            opLdi: begin
                result    = {{(dataW-8){1'b0}}, decodeIn.imm8};
                writesReg = 1'b1;
            end
            opAdd: begin
                result    = decodeIn.opA + decodeIn.opB;
                writesReg = 1'b1;
            end
            opSub: begin
                result    = decodeIn.opA - decodeIn.opB;
                writesReg = 1'b1;
            end
            opAnd: begin
                result    = decodeIn.opA & decodeIn.opB;
                writesReg = 1'b1;
            end
            opIn: begin
                // only the pin port exists on the input side
                result    = (decodeIn.port == portPins) ? pinData : '0;
                writesReg = 1'b1;
            end
            default: begin
                result    = '0;
                writesReg = 1'b0;
            end
        endcase
    end

    // writes to r0 are dropped here so the bypass never sees them
    assign wb.en   = decodeIn.valid && writesReg && (decodeIn.rd != '0);
    assign wb.addr = decodeIn.rd;
    assign wb.data = result;

    // branch resolution on the rd operand
    assign redirect.taken = decodeIn.valid &&
        ((decodeIn.op == opBz && decodeIn.opA == '0) ||
         (decodeIn.op == opBnz && decodeIn.opA != '0));
    assign redirect.target = decodeIn.pc + branchOffset;

    // OUT goes straight to the gpio block
    assign ioWr.we   = decodeIn.valid && (decodeIn.op == opOut);
    assign ioWr.port = decodeIn.port;
    assign ioWr.data = decodeIn.opA;

endmodule

`default_nettype wire

// ==== rtl/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic                     clk,
    input  logic                     arstN,
    input  cpuPkg::redirectT         redirect,
    input  logic [cpuPkg::dataW-1:0] instr,
    output logic [cpuPkg::addrW-1:0] pc,
    output cpuPkg::fetchT            fetchOut
);
    import cpuPkg::*;

    logic [addrW-1:0] pcNext;
    logic             fetchValid;
    logic [addrW-1:0] fetchPc;
    logic [dataW-1:0] fetchInstr;

    // taken branch overrides the sequential pc
    always_comb begin
        if (redirect.taken) begin
            pcNext = redirect.target;
        end else begin
            pcNext = pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc         <= '0;
            fetchValid <= 1'b0;
        end else begin
            pc         <= pcNext;
            // word fetched under a taken branch is wrong path
            fetchValid <= !redirect.taken;
        end
    end

    // rom word tagged with its own address
    always_ff @(posedge clk) begin
        fetchPc    <= pc;
        fetchInstr <= instr;
    end

    assign fetchOut = '{valid: fetchValid, pc: fetchPc, instr: fetchInstr};

endmodule

`default_nettype wire

// ==== rtl/gpioPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpioPort (
    input  logic                     clk,
    input  logic                     arstN,
    input  cpuPkg::ioWrT             ioWr,
    input  logic [cpuPkg::pinW-1:0]  pins,
    output logic [cpuPkg::dataW-1:0] pinData,
    output logic [cpuPkg::dataW-1:0] dataOut,
    output logic [cpuPkg::dataW-1:0] statusOut,
    output logic                     dataStrobe
);
    import cpuPkg::*;

    logic [pinW-1:0] pinMeta;
    logic [pinW-1:0] pinSync;
    logic            dataWrite;
    logic            statusWrite;

    // two flop synchronizer on the async pins
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pinMeta <= '0;
            pinSync <= '0;
        end else begin
            pinMeta <= pins;
            pinSync <= pinMeta;
        end
    end

    assign pinData = {{(dataW-pinW){1'b0}}, pinSync};

    // port decode
    assign dataWrite   = ioWr.we && (ioWr.port == portData);
    assign statusWrite = ioWr.we && (ioWr.port == portStatus);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataOut    <= '0;
            statusOut  <= '0;
            dataStrobe <= 1'b0;
        end else begin
            // strobe marks the cycle dataOut changes
            dataStrobe <= dataWrite;
            if (dataWrite) begin
                dataOut <= ioWr.data;
            end
            if (statusWrite) begin
                statusOut <= ioWr.data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instructionRom.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionRom (
    input  logic [cpuPkg::addrW-1:0] addr,
    output logic [cpuPkg::dataW-1:0] instr
);
    import cpuPkg::*;

    // r3 pins, r4 start mask, r5 count mask, r8 fib value
    // r9 iteration counter, r10 previous value, r11 next value
    // r12 constant one, r13 start flag
    always_comb begin
        case (addr)
            // constants
            10'h000 : instr = {opLdi, 4'd4, 8'h80};
            10'h001 : instr = {opLdi, 4'd5, 8'h7f};
            10'h002 : instr = {opLdi, 4'd12, 8'h01};
            // spin until start pin goes high
            10'h003 : instr = {opIn, 4'd3, 4'd0, portPins};
            10'h004 : instr = {opAnd, 4'd13, 4'd3, 4'd4};
            10'h005 : instr = {opBz, 4'd13, 8'hfe};
            // N from pins, F1 = 1 and F0 = 0
            10'h006 : instr = {opAnd, 4'd9, 4'd3, 4'd5};
            10'h007 : instr = {opLdi, 4'd8, 8'h01};
            10'h008 : instr = {opLdi, 4'd10, 8'h00};
            // N == 0 skips straight to done
            10'h009 : instr = {opBz, 4'd9, 8'h07};
            // fib loop
            10'h00a : instr = {opOut, 4'd8, 4'd0, portData};
            10'h00b : instr = {opAdd, 4'd11, 4'd8, 4'd10};
            10'h00c : instr = {opAdd, 4'd10, 4'd8, 4'd0};
            10'h00d : instr = {opAdd, 4'd8, 4'd11, 4'd0};
            10'h00e : instr = {opSub, 4'd9, 4'd9, 4'd12};
            10'h00f : instr = {opBnz, 4'd9, 8'hfb};
            // done, raise status
            10'h010 : instr = {opOut, 4'd12, 4'd0, portStatus};
            // spin until start drops
            10'h011 : instr = {opIn, 4'd3, 4'd0, portPins};
            10'h012 : instr = {opAnd, 4'd13, 4'd3, 4'd4};
            10'h013 : instr = {opBnz, 4'd13, 8'hfe};
            // clear status, back to the start wait
            10'h014 : instr = {opOut, 4'd0, 4'd0, portStatus};
            10'h015 : instr = {opBz, 4'd0, 8'hee};
            default : instr = {opNop, 12'h000};
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/microCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module microCore (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic [cpuPkg::pinW-1:0]  pins,
    output logic [cpuPkg::dataW-1:0] dataOut,
    output logic [cpuPkg::dataW-1:0] statusOut,
    output logic                     dataStrobe
);
    import cpuPkg::*;

    logic [addrW-1:0] pc;
    logic [dataW-1:0] instr;
    logic [dataW-1:0] pinData;
    fetchT            fetchBus;
    decodeT           decodeBus;
    wbT               wbBus;
    redirectT         redirectBus;
    ioWrT             ioWrBus;

    // program store, read by the fetch pc
    instructionRom uRom (.addr(pc), .instr(instr));

    fetchStage uFetch (
        .clk(clk), .arstN(arstN), .redirect(redirectBus),
        .instr(instr), .pc(pc), .fetchOut(fetchBus)
    );

    // writeback feeds both the register file and the bypass
    decodeStage uDecode (
        .clk(clk), .arstN(arstN), .fetchIn(fetchBus),
        .wb(wbBus), .redirect(redirectBus), .decodeOut(decodeBus)
    );

    executeStage uExecute (
        .decodeIn(decodeBus), .pinData(pinData), .wb(wbBus),
        .redirect(redirectBus), .ioWr(ioWrBus)
    );

    gpioPort uGpio (
        .clk(clk), .arstN(arstN), .ioWr(ioWrBus), .pins(pins),
        .pinData(pinData), .dataOut(dataOut), .statusOut(statusOut),
        .dataStrobe(dataStrobe)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the microCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=microCoreSim

if ! verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module microCoreTb -Mdir obj_dir -o "$BIN"; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/microCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module microCoreTb;
    import cpuPkg::*;

    localparam int clkHalf    = 2;
    localparam int maxRandomN = 127;
    localparam int idleCycles = 50;
    localparam int dropLimit  = 40;

    logic             clk;
    logic             arstN;
    logic [pinW-1:0]  pins;
    logic [dataW-1:0] dataOut;
    logic [dataW-1:0] statusOut;
    logic             dataStrobe;
    logic [15:0]      lfsrState;
    logic [15:0]      collected[$];
    int               errorCount;
    int               checkCount;

    microCore DUT (
        .clk(clk), .arstN(arstN), .pins(pins),
        .dataOut(dataOut), .statusOut(statusOut), .dataStrobe(dataStrobe)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clkHalf clk = ~clk;
        end
    end

    // galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // F1 = F2 = 1 and wraps at 16 bits
    function automatic logic [15:0] fibModel(input int k);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] t;
        a = 16'h0000;
        b = 16'h0001;
        for (int i = 1; i < k; i++) begin
            t = a + b;
            a = b;
            b = t;
        end
        return b;
    endfunction

    // cycles allowed for one run of N values
    function automatic int testBudget(input int n);
        return 64 * n + 200;
    endfunction

    // core spins on the start pin so the outputs stay quiet
    task automatic idleAfterReset();
        repeat (idleCycles) begin
            @(negedge clk);
            checkCount++;
            assert (dataStrobe == 1'b0) else begin
                $display("CHECK FAILED dataStrobe expected 0x0 got 0x%0h", dataStrobe);
                errorCount++;
            end
            checkCount++;
            assert (dataOut == 16'h0000) else begin
                $display("CHECK FAILED dataOut expected 0x0000 got 0x%04h", dataOut);
                errorCount++;
            end
            checkCount++;
            assert (statusOut == 16'h0000) else begin
                $display("CHECK FAILED statusOut expected 0x0000 got 0x%04h", statusOut);
                errorCount++;
            end
        end
    endtask

    // drive start plus N and gather strobes until status rises
    task automatic runSequence(input int n);
        int cycles;
        int limit;
        logic [15:0] expected;
        collected.delete();
        limit = testBudget(n);
        cycles = 0;
        @(negedge clk);
        pins = 8'h80 | 8'(n);
        // strobe is stable for a whole cycle around the falling edge
        while (statusOut != 16'h0001 && cycles < limit) begin
            @(negedge clk);
            if (dataStrobe) begin
                collected.push_back(dataOut);
            end
            cycles++;
        end
        checkCount++;
        assert (statusOut == 16'h0001) else begin
            $display("CHECK FAILED statusOut expected 0x0001 got 0x%04h", statusOut);
            errorCount++;
        end
        checkCount++;
        assert (collected.size() == n) else begin
            $display("wrong number of data values for N=%0d: expected %0d, collected %0d",
                n, n, collected.size());
            errorCount++;
        end
        for (int i = 0; i < n && i < collected.size(); i++) begin
            expected = fibModel(i + 1);
            checkCount++;
            assert (collected[i] == expected) else begin
                $display("CHECK FAILED dataOut[%0d] expected 0x%04h got 0x%04h",
                    i, expected, collected[i]);
                errorCount++;
            end
        end
        // status clears once start drops
        @(negedge clk);
        pins = 8'h00;
        cycles = 0;
        while (statusOut != 16'h0000 && cycles < dropLimit) begin
            @(negedge clk);
            cycles++;
        end
        checkCount++;
        assert (statusOut == 16'h0000) else begin
            $display("statusOut did not return to zero after start dropped, N=%0d", n);
            errorCount++;
        end
    endtask

    // F25 past the 16 bit wrap
    task automatic wrapTest();
        runSequence(30);
        if (collected.size() > 24) begin
            checkCount++;
            assert (collected[24] == 16'h2511) else begin
                $display("CHECK FAILED dataOut[24] expected 0x2511 got 0x%04h", collected[24]);
                errorCount++;
            end
        end
    endtask

    // N from seven lfsr bits per run
    task automatic randomRuns();
        int n;
        repeat (4) begin
            drawBits(7, n);
            runSequence(n);
        end
    endtask

    initial begin : watchdog
        int budget;
        budget = 10 + idleCycles + 200 + testBudget(1) + testBudget(12) + testBudget(30)
            + testBudget(0) + 4 * testBudget(maxRandomN);
        repeat (budget) @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", budget);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        arstN = 1'b0;
        pins = 8'h00;
        errorCount = 0;
        checkCount = 0;
        lfsrState = 16'd2030;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        idleAfterReset();
        runSequence(1);
        // back to back adds and the loop branch
        runSequence(12);
        wrapTest();
        // BZ skips the loop and gives no strobes
        runSequence(0);
        randomRuns();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/microCore_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module microCoreSva (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic [cpuPkg::dataW-1:0] dataOut,
    input  logic [cpuPkg::dataW-1:0] statusOut,
    input  logic                     dataStrobe
);
    import cpuPkg::*;

    // one OUT per strobe, never two in a row
    strobeSingle: assert property (@(posedge clk) disable iff (!arstN)
        dataStrobe |=> !dataStrobe)
        else $error("dataStrobe high on two consecutive cycles");

    // status port only carries the done flag
    statusBinary: assert property (@(posedge clk) disable iff (!arstN)
        statusOut <= 16'h0001)
        else $error("statusOut holds a value other than 0 or 1");

    // outputs cleared while reset is held
    resetQuiet: assert property (@(posedge clk)
        !arstN |-> (dataOut == '0 && statusOut == '0 && !dataStrobe))
        else $error("outputs not zero during reset");

endmodule

bind gpioPort microCoreSva uSva (
    .clk(clk), .arstN(arstN), .dataOut(dataOut),
    .statusOut(statusOut), .dataStrobe(dataStrobe)
);

`default_nettype wire

// ==== vlog.f ====
rtl/cpuPkg.sv
rtl/instructionRom.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/gpioPort.sv
rtl/microCore.sv
verif/microCoreTb.sv
verif/microCore_sva.sv
